// File: list.f
logic/dsp_pkg.sv
logic/dsp_cfg_regs.sv
logic/code_history.sv
logic/ffe_filter.sv
logic/bit_slicer.sv
logic/mlsd_checker.sv
logic/dsp_backend.sv
testbench/dsp_backend_assert.sv
testbench/dsp_backend_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the dsp_backend testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module dsp_backend_tb \
	-f list.f --Mdir obj_dir -o sim_dsp_backend > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "compile failed, see build.log"
	exit 1
fi

./obj_dir/sim_dsp_backend > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -qx "TEST RESULT: PASS" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see sim.log"
exit 1

// File: testbench/dsp_backend_tb.sv
module dsp_backend_tb;
	import dsp_pkg::*;

	logic clk;
	logic rstb;
	logic [channel_width-1:0][code_precision-1:0] codes;
	logic in_valid;
	logic cfg_we;
	logic [cfg_addr_width-1:0] cfg_addr;
	cfg_word_u cfg_wdata;
	logic [channel_width-1:0][output_precision-1:0] estimated_bits;
	logic est_valid;
	logic [channel_width-1:0] checked_bits;
	logic chk_valid;

	// model of the configuration as the DUT should hold it
	int w [channel_width][ffe_length];
	int ce [channel_width][estimate_depth];
	int th [channel_width];
	int fsh [channel_width];
	int msh [channel_width];
	int cur [channel_width];
	int h1 [channel_width];  // word one edge old
	int h2 [channel_width];  // word two edges old
	int exp_est [channel_width];
	logic [channel_width-1:0] exp_bits, exp_pbits, exp_chk, exp_flip;
	logic [2:0] exp_valid;

	integer seed;
	int errors, checks, tests, sat_hi, sat_lo, flips;
	logic [channel_width-1:0] pattern_q [$];
	logic check_pattern;

	dsp_backend DUT (
		.clk              (clk),
		.rstb             (rstb),
		.codes_i          (codes),
		.in_valid_i       (in_valid),
		.cfg_we_i         (cfg_we),
		.cfg_addr_i       (cfg_addr),
		.cfg_wdata_i      (cfg_wdata),
		.estimated_bits_o (estimated_bits),
		.est_valid_o      (est_valid),
		.checked_bits_o   (checked_bits),
		.chk_valid_o      (chk_valid)
	);

	always #50 clk = ~clk;

	// three-tap fir over the sample stream, shifted and clamped
	function automatic int ffe_ref(input int c);
		int acc;
		int s;
		acc = 0;
		for (int k = 0; k < ffe_length; k++) begin
			s = (c - k >= 0) ? cur[c - k] : h1[channel_width + c - k];
			acc += w[c][k] * s;
		end
		acc = acc >>> fsh[c];
		if (acc > est_max) begin
			acc = est_max;
		end else if (acc < est_min) begin
			acc = est_min;
		end
		return acc;
	endfunction

	// keep or flip the sliced bit, whichever prediction is closer to the code
	function automatic logic mlsd_ref(input int c);
		int past, sb, pk, pf, dk, df;
		logic b;
		past = 0;
		for (int j = 1; j < estimate_depth; j++) begin
			b = (c - j >= 0) ? exp_bits[c - j] : exp_pbits[channel_width + c - j];
			if (b) begin
				past += ce[c][j];
			end else begin
				past -= ce[c][j];
			end
		end
		sb = exp_bits[c] ? 1 : -1;
		pk = (past + sb * ce[c][0]) >>> msh[c];
		pf = (past - sb * ce[c][0]) >>> msh[c];
		dk = (h2[c] > pk) ? h2[c] - pk : pk - h2[c];
		df = (h2[c] > pf) ? h2[c] - pf : pf - h2[c];
		return (df < dk) ? !exp_bits[c] : exp_bits[c];
	endfunction

	task automatic store_write;
		int lane;
		int tap;
		lane = cfg_addr[3:2];
		tap = cfg_addr[1:0];
		case (cfg_addr[5:4])
			cfg_kind_weight: begin
				if (tap < ffe_length) w[lane][tap] = $signed(cfg_wdata.coef.value);
			end
			cfg_kind_chan_est: begin
				if (tap < estimate_depth) ce[lane][tap] = $signed(cfg_wdata.coef.value);
			end
			cfg_kind_slicer: begin
				th[lane] = $signed(cfg_wdata.ctrl.thresh);
				fsh[lane] = cfg_wdata.ctrl.shift;
			end
			default: msh[lane] = cfg_wdata.ctrl.shift;
		endcase
	endtask

	// later stages update first so each sees last cycle's state
	always @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			for (int c = 0; c < channel_width; c++) begin
				for (int k = 0; k < 3; k++) begin
					w[c][k] = 0;
					ce[c][k] = 0;
				end
				th[c] = 0;
				fsh[c] = 0;
				msh[c] = 0;
				cur[c] = 0;
				h1[c] = 0;
				h2[c] = 0;
				exp_est[c] = 0;
			end
			exp_bits = '0;
			exp_pbits = '0;
			exp_chk = '0;
			exp_flip = '0;
			exp_valid = '0;
		end else begin
			for (int c = 0; c < channel_width; c++) begin
				cur[c] = $signed(codes[c]);
				exp_chk[c] = mlsd_ref(c);
				exp_flip[c] = exp_chk[c] ^ exp_bits[c];
			end
			exp_pbits = exp_bits;
			for (int c = 0; c < channel_width; c++) begin
				exp_bits[c] = exp_est[c] >= th[c];
				exp_est[c] = ffe_ref(c);
			end
			h2 = h1;
			h1 = cur;
			exp_valid = {exp_valid[1:0], in_valid};
			if (cfg_we) store_write();  // takes effect from the next edge
		end
	end

	always @(negedge clk) begin : compare
		logic [channel_width-1:0] pat;
		if (rstb) begin
			if (est_valid !== exp_valid[0] || chk_valid !== exp_valid[2]) begin
				errors++;
				$display("Error at %0t: est_valid_o/chk_valid_o are %b/%b, expected %b/%b",
					$time, est_valid, chk_valid, exp_valid[0], exp_valid[2]);
			end
			for (int c = 0; c < channel_width && est_valid; c++) begin
				checks++;
				if ($signed(estimated_bits[c]) != exp_est[c]) begin
					errors++;
					$display("Error at %0t: estimated_bits_o[%0d] is %0d, expected %0d",
						$time, c, $signed(estimated_bits[c]), exp_est[c]);
				end
				if (exp_est[c] == est_max) sat_hi++;
				if (exp_est[c] == est_min) sat_lo++;
			end
			if (chk_valid) begin
				checks++;
				if (checked_bits !== exp_chk) begin
					errors++;
					$display("Error at %0t: checked_bits_o is %b, expected %b",
						$time, checked_bits, exp_chk);
				end
				if (check_pattern && pattern_q.size() == 0) begin
					errors++;
					$display("a checked word arrived with no pattern word left to compare");
				end else if (check_pattern) begin
					pat = pattern_q.pop_front();
					for (int c = 0; c < channel_width; c++) begin
						if (exp_flip[c]) begin
							flips++;
							if (checked_bits[c] !== pat[c]) begin
								errors++;
								$display("Error at %0t: checked_bits_o[%0d] is %b, expected %b",
									$time, c, checked_bits[c], pat[c]);
							end
						end
					end
				end
			end
		end
	end

	task automatic send_word(input logic v, input logic [31:0] word);
		@(posedge clk);
		#1;
		cfg_we = 1'b0;
		in_valid = v;
		codes = v ? word : '0;  // gaps carry zero codes
	endtask

	task automatic cfg_write(input logic [1:0] kind, input int lane, input int tap,
		input cfg_word_u data);
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		codes = '0;
		cfg_we = 1'b1;
		cfg_addr = {kind, 2'(lane), 2'(tap)};
		cfg_wdata = data;
	endtask

	task automatic set_lane(input int c, input int w0, input int w1, input int w2,
		input int thresh, input int shift);
		cfg_word_u d;
		d = '0;
		d.coef.value = 8'(w0);
		cfg_write(cfg_kind_weight, c, 0, d);
		d.coef.value = 8'(w1);
		cfg_write(cfg_kind_weight, c, 1, d);
		d.coef.value = 8'(w2);
		cfg_write(cfg_kind_weight, c, 2, d);
		d = '0;
		d.ctrl.thresh = 10'(thresh);
		d.ctrl.shift = 3'(shift);
		cfg_write(cfg_kind_slicer, c, 0, d);
	endtask

	task automatic set_chan(input int c, input int e0, input int e1, input int e2, input int sh);
		cfg_word_u d;
		d = '0;
		d.coef.value = 8'(e0);
		cfg_write(cfg_kind_chan_est, c, 0, d);
		d.coef.value = 8'(e1);
		cfg_write(cfg_kind_chan_est, c, 1, d);
		d.coef.value = 8'(e2);
		cfg_write(cfg_kind_chan_est, c, 2, d);
		d = '0;
		d.ctrl.shift = 3'(sh);
		cfg_write(cfg_kind_mlsd, c, 0, d);
	endtask

	// wait for three quiet cycles so nothing is left in flight
	task automatic drain;
		int n;
		int quiet;
		send_word(1'b0, '0);
		n = 0;
		quiet = 0;
		while (quiet < 3 && n < 20) begin
			@(posedge clk);
			#1;
			quiet = (est_valid || chk_valid) ? 0 : quiet + 1;
			n++;
		end
		if (quiet < 3) begin
			errors++;
			$display("timeout: the valid outputs did not settle after the stream ended");
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		if (errors == err_before) begin
			$display("test %0d %s: passed", tests, name);
		end else begin
			$display("test %0d %s: failed with %0d errors", tests, name, errors - err_before);
		end
	endtask

	task automatic check_idle;
		checks++;
		if (est_valid !== 1'b0 || chk_valid !== 1'b0) begin
			errors++;
			$display("Error at %0t: est_valid_o/chk_valid_o are %b/%b, expected 0/0",
				$time, est_valid, chk_valid);
		end
		if (estimated_bits !== '0) begin
			errors++;
			$display("Error at %0t: estimated_bits_o is %h, expected 0",
				$time, estimated_bits);
		end
		if (checked_bits !== '0) begin
			errors++;
			$display("Error at %0t: checked_bits_o is %b, expected 0",
				$time, checked_bits);
		end
	endtask

	initial begin : stimulus
		int err0;
		int code;
		logic pb;
		logic prev;
		logic [channel_width-1:0] pat;
		logic [31:0] word;
		clk = 1'b0;
		rstb = 1'b0;
		codes = '0;
		in_valid = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		seed = 26;
		errors = 0;
		checks = 0;
		tests = 0;
		flips = 0;
		check_pattern = 1'b0;

		err0 = errors;
		for (int i = 0; i < 4; i++) begin
			@(negedge clk);
			check_idle();
		end
		@(posedge clk);
		#1;
		rstb = 1'b1;
		@(negedge clk);
		check_idle();
		report_test("reset", err0);

		err0 = errors;
		for (int c = 0; c < channel_width; c++) begin
			set_lane(c, 1, 0, 0, 0, 0);
			set_chan(c, 0, 0, 0, 0);
		end
		for (int i = 0; i < 40; i++) send_word(1'b1, $random(seed));
		drain();
		report_test("identity", err0);

		err0 = errors;
		// drives lane 0 into both limits
		set_lane(0, 127, $random(seed), $random(seed), $random(seed), 0);
		for (int c = 1; c < channel_width; c++) begin
			set_lane(c, $random(seed), $random(seed), $random(seed), $random(seed),
				$random(seed) & 7);
		end
		sat_hi = 0;
		sat_lo = 0;
		for (int i = 0; i < 60; i++) send_word(1'b1, $random(seed));
		drain();
		if (sat_hi == 0 || sat_lo == 0) begin
			errors++;
			$display("saturation at both limits was not reached (%0d high, %0d low)",
				sat_hi, sat_lo);
		end
		report_test("random weights", err0);

		// codes from the channel 40*s(n) + 20*s(n-1), read with a threshold that misjudges
		err0 = errors;
		for (int c = 0; c < channel_width; c++) begin
			set_lane(c, 1, 0, 0, 30, 0);
			set_chan(c, 40, 20, 0, 0);
		end
		drain();
		check_pattern = 1'b1;
		pb = 1'b0;
		for (int i = 0; i < 40; i++) begin
			pat = $random(seed);
			for (int c = 0; c < channel_width; c++) begin
				prev = (c == 0) ? pb : pat[c-1];
				code = (pat[c] ? 40 : -40) + (prev ? 20 : -20);
				word[c*8 +: 8] = 8'(code);
			end
			pb = pat[channel_width-1];
			pattern_q.push_back(pat);
			send_word(1'b1, word);
		end
		drain();
		check_pattern = 1'b0;
		if (flips == 0 || pattern_q.size() != 0) begin
			errors++;
			$display("pattern check incomplete: %0d corrected bits, %0d words unchecked",
				flips, pattern_q.size());
		end
		report_test("sequence check", err0);

		err0 = errors;
		for (int c = 0; c < channel_width; c++) begin
			set_lane(c, $random(seed), $random(seed), $random(seed), $random(seed),
				$random(seed) & 7);
			set_chan(c, $random(seed), $random(seed), $random(seed), $random(seed) & 7);
		end
		for (int i = 0; i < 80; i++) begin
			if (i == 30 || i == 50) begin
				set_lane(2, $random(seed), $random(seed), $random(seed), $random(seed), 1);
				set_chan(2, $random(seed), $random(seed), 0, 2);
			end
			send_word(($random(seed) & 3) != 0, $random(seed));
		end
		drain();
		report_test("gaps and lane writes", err0);

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: testbench/dsp_backend_assert.sv
module dsp_backend_assert (
	input logic clk,
	input logic rstb,
	input logic in_valid_i,
	input logic [dsp_pkg::channel_width-1:0][dsp_pkg::output_precision-1:0] estimated_bits_o,
	input logic est_valid_o,
	input logic [dsp_pkg::channel_width-1:0] checked_bits_o,
	input logic chk_valid_o
);

	a_est_valid: assert property (@(posedge clk) disable iff (!rstb)
		est_valid_o == $past(in_valid_i))
		else $error("est_valid_o is not in_valid_i delayed by one cycle");

	a_chk_valid: assert property (@(posedge clk) disable iff (!rstb)
		chk_valid_o == $past(in_valid_i, 3))
		else $error("chk_valid_o is not in_valid_i delayed by three cycles");

	a_est_known: assert property (@(posedge clk) disable iff (!rstb)
		est_valid_o |-> !$isunknown(estimated_bits_o))
		else $error("estimated_bits_o has unknown bits while valid");

	a_chk_known: assert property (@(posedge clk) disable iff (!rstb)
		chk_valid_o |-> !$isunknown(checked_bits_o))
		else $error("checked_bits_o has unknown bits while valid");

endmodule

bind dsp_backend dsp_backend_assert u_assert (
	.clk              (clk),
	.rstb             (rstb),
	.in_valid_i       (in_valid_i),
	.estimated_bits_o (estimated_bits_o),
	.est_valid_o      (est_valid_o),
	.checked_bits_o   (checked_bits_o),
	.chk_valid_o      (chk_valid_o)
);

// File: logic/dsp_backend.sv
module dsp_backend (
	input  logic clk,
	input  logic rstb,
	input  logic [dsp_pkg::channel_width-1:0][dsp_pkg::code_precision-1:0] codes_i,
	input  logic in_valid_i,
	input  logic cfg_we_i,
	input  logic [dsp_pkg::cfg_addr_width-1:0] cfg_addr_i,
	input  dsp_pkg::cfg_word_u cfg_wdata_i,
	output logic [dsp_pkg::channel_width-1:0][dsp_pkg::output_precision-1:0] estimated_bits_o,
	output logic est_valid_o,
	output logic [dsp_pkg::channel_width-1:0] checked_bits_o,
	output logic chk_valid_o
);
	import dsp_pkg::*;

	logic [channel_width-1:0][ffe_length-1:0][weight_precision-1:0] weights;
	logic [channel_width-1:0][estimate_depth-1:0][estimate_precision-1:0] chan_est;
	logic [channel_width-1:0][thresh_precision-1:0] thresh;
	logic [channel_width-1:0][ffe_shift_precision-1:0] ffe_shift;
	logic [channel_width-1:0][mlsd_shift_precision-1:0] mlsd_shift;

	logic [code_history_depth-1:0][channel_width-1:0][code_precision-1:0] code_hist;
	logic [channel_width-1:0] sliced_bits;
	logic [channel_width-1:0] sliced_prev_bits;
	logic [2:0] valid_q;  // valid delay line, one entry per pipeline stage

	dsp_cfg_regs u_cfg_regs (
		.clk          (clk),
		.rstb         (rstb),
		.cfg_we_i     (cfg_we_i),
		.cfg_addr_i   (cfg_addr_i),
		.cfg_wdata_i  (cfg_wdata_i),
		.weights_o    (weights),
		.chan_est_o   (chan_est),
		.thresh_o     (thresh),
		.ffe_shift_o  (ffe_shift),
		.mlsd_shift_o (mlsd_shift)
	);

	code_history u_code_history (
		.clk     (clk),
		.rstb    (rstb),
		.codes_i (codes_i),
		.hist_o  (code_hist)
	);

	ffe_filter u_ffe (
		.clk          (clk),
		.rstb         (rstb),
		.curr_codes_i (code_hist[0]),
		.prev_codes_i (code_hist[1]),
		.weights_i    (weights),
		.ffe_shift_i  (ffe_shift),
		.est_o        (estimated_bits_o)
	);

	bit_slicer u_slicer (
		.clk         (clk),
		.rstb        (rstb),
		.est_i       (estimated_bits_o),
		.thresh_i    (thresh),
		.bits_o      (sliced_bits),
		.prev_bits_o (sliced_prev_bits)
	);

	// codes two cycles old line up with the sliced word
	mlsd_checker u_mlsd (
		.clk          (clk),
		.rstb         (rstb),
		.bits_i       (sliced_bits),
		.prev_bits_i  (sliced_prev_bits),
		.codes_i      (code_hist[2]),
		.chan_est_i   (chan_est),
		.mlsd_shift_i (mlsd_shift),
		.checked_o    (checked_bits_o)
	);

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			valid_q <= '0;
		end else begin
			valid_q <= {valid_q[1:0], in_valid_i};
		end
	end

	assign est_valid_o = valid_q[0];  // ffe stage
	assign chk_valid_o = valid_q[2];  // ffe, slicer and checker stages

endmodule

// File: logic/mlsd_checker.sv
module mlsd_checker (
	input  logic clk,
	input  logic rstb,
	input  logic [dsp_pkg::channel_width-1:0] bits_i,
	input  logic [dsp_pkg::channel_width-1:0] prev_bits_i,
	input  logic [dsp_pkg::channel_width-1:0][dsp_pkg::code_precision-1:0] codes_i,
	input  logic [dsp_pkg::channel_width-1:0][dsp_pkg::estimate_depth-1:0]
		[dsp_pkg::estimate_precision-1:0] chan_est_i,
	input  logic [dsp_pkg::channel_width-1:0][dsp_pkg::mlsd_shift_precision-1:0] mlsd_shift_i,
	output logic [dsp_pkg::channel_width-1:0] checked_o
);
	import dsp_pkg::*;

	// bit n of lane c sits at channel_width+c, older bits below it
	logic [2*channel_width-1:0] bit_win;
	logic [channel_width-1:0] checked_d;

	assign bit_win = {bits_i, prev_bits_i};

	for (genvar c = 0; c < channel_width; c++) begin : g_lane
		logic signed [mlsd_pred_width-1:0] past_sum;
		logic signed [mlsd_pred_width-1:0] pred_keep;
		logic signed [mlsd_pred_width-1:0] pred_flip;
		logic signed [mlsd_diff_width-1:0] diff_keep;
		logic signed [mlsd_diff_width-1:0] diff_flip;
		logic [mlsd_diff_width-1:0] abs_keep;
		logic [mlsd_diff_width-1:0] abs_flip;
		logic flip_wins;

		// past symbols as sliced, +1 for bit 1 and -1 for bit 0
		always_comb begin
			past_sum = '0;
			for (int j = 1; j < estimate_depth; j++) begin
				if (bit_win[channel_width + c - j]) begin
					past_sum = past_sum + $signed(chan_est_i[c][j]);
				end else begin
					past_sum = past_sum - $signed(chan_est_i[c][j]);
				end
			end
		end

		// the cursor term enters with the sliced sign or the flipped one
		always_comb begin
			if (bits_i[c]) begin
				pred_keep = past_sum + $signed(chan_est_i[c][0]);
				pred_flip = past_sum - $signed(chan_est_i[c][0]);
			end else begin
				pred_keep = past_sum - $signed(chan_est_i[c][0]);
				pred_flip = past_sum + $signed(chan_est_i[c][0]);
			end
		end

		assign diff_keep = $signed(codes_i[c]) - (pred_keep >>> mlsd_shift_i[c]);
		assign diff_flip = $signed(codes_i[c]) - (pred_flip >>> mlsd_shift_i[c]);
		assign abs_keep = diff_keep < 0 ? -diff_keep : diff_keep;
		assign abs_flip = diff_flip < 0 ? -diff_flip : diff_flip;
		assign flip_wins = abs_flip < abs_keep;  // tie keeps the sliced bit

		assign checked_d[c] = bits_i[c] ^ flip_wins;
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			checked_o <= '0;
		end else begin
			checked_o <= checked_d;
		end
	end

endmodule

// File: logic/bit_slicer.sv
module bit_slicer (
	input  logic clk,
	input  logic rstb,
	input  logic [dsp_pkg::channel_width-1:0][dsp_pkg::output_precision-1:0] est_i,
	input  logic [dsp_pkg::channel_width-1:0][dsp_pkg::thresh_precision-1:0] thresh_i,
	output logic [dsp_pkg::channel_width-1:0] bits_o,
	output logic [dsp_pkg::channel_width-1:0] prev_bits_o
);
	import dsp_pkg::*;

	logic [channel_width-1:0] bits_d;

	always_comb begin
		for (int c = 0; c < channel_width; c++) begin
			bits_d[c] = $signed(est_i[c]) >= $signed(thresh_i[c]);  // tie slices to 1
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			bits_o <= '0;
			prev_bits_o <= '0;
		end else begin
			bits_o <= bits_d;
			prev_bits_o <= bits_o;  // past-bit window for the checker
		end
	end

endmodule

// File: logic/ffe_filter.sv
module ffe_filter (
	input  logic clk,
	input  logic rstb,
	input  logic [dsp_pkg::channel_width-1:0][dsp_pkg::code_precision-1:0] curr_codes_i,
	input  logic [dsp_pkg::channel_width-1:0][dsp_pkg::code_precision-1:0] prev_codes_i,
	input  logic [dsp_pkg::channel_width-1:0][dsp_pkg::ffe_length-1:0]
		[dsp_pkg::weight_precision-1:0] weights_i,
	input  logic [dsp_pkg::channel_width-1:0][dsp_pkg::ffe_shift_precision-1:0] ffe_shift_i,
	output logic [dsp_pkg::channel_width-1:0][dsp_pkg::output_precision-1:0] est_o
);
	import dsp_pkg::*;

	// previous word in the low lanes, so sample n-k sits at channel_width+c-k
	logic [2*channel_width-1:0][code_precision-1:0] code_win;
	logic [channel_width-1:0][output_precision-1:0] est_d;

	assign code_win = {curr_codes_i, prev_codes_i};

	for (genvar c = 0; c < channel_width; c++) begin : g_lane
		logic signed [ffe_sum_width-1:0] acc;
		logic signed [ffe_sum_width-1:0] acc_sh;

		always_comb begin
			acc = '0;
			for (int k = 0; k < ffe_length; k++) begin
				acc = acc + $signed(weights_i[c][k])
					* $signed(code_win[channel_width + c - k]);
			end
		end

		assign acc_sh = acc >>> ffe_shift_i[c];

		// clamp to the estimate range
		always_comb begin
			if (acc_sh > est_max) begin
				est_d[c] = output_precision'(est_max);
			end else if (acc_sh < est_min) begin
				est_d[c] = output_precision'(est_min);
			end else begin
				est_d[c] = acc_sh[output_precision-1:0];
			end
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			est_o <= '0;
		end else begin
			est_o <= est_d;
		end
	end

endmodule

// File: logic/code_history.sv
module code_history (
	input  logic clk,
	input  logic rstb,
	input  logic [dsp_pkg::channel_width-1:0][dsp_pkg::code_precision-1:0] codes_i,
	output logic [dsp_pkg::code_history_depth-1:0][dsp_pkg::channel_width-1:0]
		[dsp_pkg::code_precision-1:0] hist_o
);
	import dsp_pkg::*;

	// stored words, entry i is the word i cycles old
	logic [code_history_depth-1:1][channel_width-1:0][code_precision-1:0] hist_q;

	// shifts every clock, valid or not
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			hist_q <= '0;
		end else begin
			hist_q[1] <= codes_i;
			for (int i = 2; i < code_history_depth; i++) begin
				hist_q[i] <= hist_q[i-1];
			end
		end
	end

	// entry 0 is the live word so the ffe sees it in the same cycle
	assign hist_o[0] = codes_i;
	assign hist_o[code_history_depth-1:1] = hist_q;

endmodule

// File: logic/dsp_cfg_regs.sv
module dsp_cfg_regs (
	input  logic clk,
	input  logic rstb,
	input  logic cfg_we_i,
	input  logic [dsp_pkg::cfg_addr_width-1:0] cfg_addr_i,
	input  dsp_pkg::cfg_word_u cfg_wdata_i,
	output logic [dsp_pkg::channel_width-1:0][dsp_pkg::ffe_length-1:0]
		[dsp_pkg::weight_precision-1:0] weights_o,
	output logic [dsp_pkg::channel_width-1:0][dsp_pkg::estimate_depth-1:0]
		[dsp_pkg::estimate_precision-1:0] chan_est_o,
	output logic [dsp_pkg::channel_width-1:0][dsp_pkg::thresh_precision-1:0] thresh_o,
	output logic [dsp_pkg::channel_width-1:0][dsp_pkg::ffe_shift_precision-1:0] ffe_shift_o,
	output logic [dsp_pkg::channel_width-1:0][dsp_pkg::mlsd_shift_precision-1:0] mlsd_shift_o
);
	import dsp_pkg::*;

	logic [cfg_kind_width-1:0] kind;
	logic [cfg_lane_width-1:0] lane;
	logic [cfg_tap_width-1:0] tap;

	assign kind = cfg_addr_i[5:4];
	assign lane = cfg_addr_i[3:2];
	assign tap = cfg_addr_i[1:0];

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			weights_o <= '0;
			chan_est_o <= '0;
			thresh_o <= '0;
			ffe_shift_o <= '0;
			mlsd_shift_o <= '0;
		end else if (cfg_we_i) begin
			case (kind)
				cfg_kind_weight: begin
					if (tap < ffe_length) begin  // tap 3 has no register
						weights_o[lane][tap] <= cfg_wdata_i.coef.value;
					end
				end
				cfg_kind_chan_est: begin
					if (tap < estimate_depth) begin
						chan_est_o[lane][tap] <= cfg_wdata_i.coef.value;
					end
				end
				cfg_kind_slicer: begin
					// threshold and ffe shift share one write
					thresh_o[lane] <= cfg_wdata_i.ctrl.thresh;
					ffe_shift_o[lane] <= cfg_wdata_i.ctrl.shift;
				end
				cfg_kind_mlsd: begin
					mlsd_shift_o[lane] <= cfg_wdata_i.ctrl.shift;  // threshold field unused
				end
				default: begin
				end
			endcase
		end
	end

endmodule

// File: logic/dsp_pkg.sv
package dsp_pkg;

	// lane and sample widths
	localparam int channel_width = 4;  // lanes per word, lane 0 oldest
	localparam int code_precision = 8;
	localparam int weight_precision = 8;
	localparam int ffe_length = 3;
	localparam int ffe_shift_precision = 3;
	localparam int output_precision = 10;
	localparam int thresh_precision = 10;
	localparam int estimate_depth = 3;
	localparam int estimate_precision = 8;
	localparam int mlsd_shift_precision = 3;
	localparam int code_history_depth = 3;  // current word plus two stored

	// derived datapath widths
	localparam int ffe_sum_width = code_precision + weight_precision + 2;
	localparam int est_max = 2 ** (output_precision - 1) - 1;
	localparam int est_min = -(2 ** (output_precision - 1));
	localparam int mlsd_pred_width = estimate_precision + 2;
	localparam int mlsd_diff_width = mlsd_pred_width + 1;

	// configuration address map: [5:4] kind, [3:2] lane, [1:0] tap
	localparam int cfg_addr_width = 6;
	localparam int cfg_data_width = 16;
	localparam int cfg_kind_width = 2;
	localparam int cfg_lane_width = 2;
	localparam int cfg_tap_width = 2;

	localparam logic [cfg_kind_width-1:0] cfg_kind_weight = 2'd0;
	localparam logic [cfg_kind_width-1:0] cfg_kind_chan_est = 2'd1;
	localparam logic [cfg_kind_width-1:0] cfg_kind_slicer = 2'd2;
	localparam logic [cfg_kind_width-1:0] cfg_kind_mlsd = 2'd3;

	// one write word, read as a coefficient or as slicer/checker control
	typedef union packed {
		struct packed {
			logic [cfg_data_width-weight_precision-1:0] spare;
			logic signed [weight_precision-1:0] value;
		} coef;
		struct packed {
			logic [cfg_data_width-thresh_precision-ffe_shift_precision-1:0] spare;
			logic [ffe_shift_precision-1:0] shift;  // ffe or mlsd shift by kind
			logic signed [thresh_precision-1:0] thresh;
		} ctrl;
	} cfg_word_u;

endpackage
